/* files.f */
hdl/svc_rv_bpred_pkg.sv
hdl/svc_rv_btb_update_if.sv
hdl/svc_rv_btb.sv
hdl/svc_rv_ras.sv
hdl/svc_rv_bpred_fetch.sv
hdl/svc_rv_bpred_ex.sv
hdl/svc_rv_bpred.sv
test/svc_rv_bpred_sva.sv
test/tb_svc_rv_bpred.sv

/* hdl/svc_rv_bpred.sv */
`timescale 1ns/1ps
`default_nettype none

module svc_rv_bpred import svc_rv_bpred_pkg::*; (
  input  logic clk,
  input  logic arst_n,

  // Fetch side
  input  logic fetch_valid,
  input  pc_t  fetch_pc,
  input  logic fetch_is_call,
  input  logic fetch_is_ret,
  output logic pred_taken,
  output pc_t  pred_target,

  // EX side
  input  logic is_branch_ex,
  input  logic is_jal_ex,
  input  logic is_jalr_ex,
  input  logic bpred_taken_ex,
  input  logic branch_taken_ex,
  input  pc_t  pc_ex,
  input  pc_t  jb_target_ex,
  input  pc_t  pred_target_ex,
  output logic mispredicted_ex,
  output logic pc_sel_jump_ex
);

  // BTB lookup result
  logic       btb_hit;
  bpred_ctr_t btb_ctr;
  pc_t        btb_target;

  // RAS control and top of stack
  logic ras_push;
  logic ras_pop;
  pc_t  ras_push_addr;
  pc_t  ras_top;
  logic ras_nonempty;

  // Training path from EX into the BTB
  svc_rv_btb_update_if btb_upd ();

  svc_rv_bpred_fetch u_fetch (
    .fetch_valid   (fetch_valid),
    .fetch_pc      (fetch_pc),
    .fetch_is_call (fetch_is_call),
    .fetch_is_ret  (fetch_is_ret),
    .btb_hit       (btb_hit),
    .btb_ctr       (btb_ctr),
    .btb_target    (btb_target),
    .ras_top       (ras_top),
    .ras_nonempty  (ras_nonempty),
    .ras_push      (ras_push),
    .ras_pop       (ras_pop),
    .ras_push_addr (ras_push_addr),
    .pred_taken    (pred_taken),
    .pred_target   (pred_target)
  );

  svc_rv_btb u_btb (
    .clk       (clk),
    .arst_n    (arst_n),
    .lookup_pc (fetch_pc),
    .hit       (btb_hit),
    .ctr       (btb_ctr),
    .target    (btb_target),
    .upd       (btb_upd.btb)
  );

  svc_rv_ras u_ras (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (ras_push),
    .pop       (ras_pop),
    .push_addr (ras_push_addr),
    .top       (ras_top),
    .nonempty  (ras_nonempty)
  );

  svc_rv_bpred_ex u_ex (
    .is_branch_ex    (is_branch_ex),
    .is_jal_ex       (is_jal_ex),
    .is_jalr_ex      (is_jalr_ex),
    .bpred_taken_ex  (bpred_taken_ex),
    .branch_taken_ex (branch_taken_ex),
    .pc_ex           (pc_ex),
    .jb_target_ex    (jb_target_ex),
    .pred_target_ex  (pred_target_ex),
    .mispredicted_ex (mispredicted_ex),
    .pc_sel_jump_ex  (pc_sel_jump_ex),
    .upd             (btb_upd.ex)
  );

endmodule

`default_nettype wire

/* hdl/svc_rv_bpred_ex.sv */
`timescale 1ns/1ps
`default_nettype none

module svc_rv_bpred_ex import svc_rv_bpred_pkg::*; (
  input  logic              is_branch_ex,
  input  logic              is_jal_ex,
  input  logic              is_jalr_ex,
  input  logic              bpred_taken_ex,
  input  logic              branch_taken_ex,
  input  pc_t               pc_ex,
  input  pc_t               jb_target_ex,
  input  pc_t               pred_target_ex,
  output logic              mispredicted_ex,
  output logic              pc_sel_jump_ex,
  svc_rv_btb_update_if.ex   upd
);

  logic jalr_target_bad;

  // Direction check for conditional branches
  assign mispredicted_ex = is_branch_ex && (bpred_taken_ex != branch_taken_ex);

  // Register-indirect target was either not predicted or predicted wrong
  assign jalr_target_bad = !bpred_taken_ex || (pred_target_ex != jb_target_ex);

  // JAL resolves earlier in the pipe so only JALR redirects here
  assign pc_sel_jump_ex = is_jalr_ex && jalr_target_bad;

  // Train on PC-relative control flow only
  // JALR targets depend on register values and are left out
  assign upd.en     = is_branch_ex || is_jal_ex;
  assign upd.pc     = pc_ex;
  assign upd.target = jb_target_ex;
  // JAL always counts as taken
  assign upd.taken  = is_jal_ex ? 1'b1 : branch_taken_ex;

endmodule

`default_nettype wire

/* hdl/svc_rv_bpred_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module svc_rv_bpred_fetch import svc_rv_bpred_pkg::*; (
  input  logic       fetch_valid,
  input  pc_t        fetch_pc,
  input  logic       fetch_is_call,
  input  logic       fetch_is_ret,
  input  logic       btb_hit,
  input  bpred_ctr_t btb_ctr,
  input  pc_t        btb_target,
  input  pc_t        ras_top,
  input  logic       ras_nonempty,
  output logic       ras_push,
  output logic       ras_pop,
  output pc_t        ras_push_addr,
  output logic       pred_taken,
  output pc_t        pred_target
);

  logic ret_pred;
  logic btb_pred;

  // Return predicted from the stack only when something is on it
  assign ret_pred = fetch_is_ret && ras_nonempty;

  // Counter upper bit means 2 or 3, i.e. taken
  assign btb_pred = btb_hit && btb_ctr[1];

  // Stack maintenance only for instructions actually fetched
  assign ras_push      = fetch_valid && fetch_is_call;
  assign ras_pop       = fetch_valid && fetch_is_ret;
  // Link address of the call
  assign ras_push_addr = fetch_pc + pc_t'(4);

  always_comb begin
    if (ret_pred) begin
      pred_taken  = 1'b1;
      pred_target = ras_top;
    end else begin
      // Calls fall through here too
      pred_taken  = btb_pred;
      pred_target = btb_target;
    end
  end

endmodule

`default_nettype wire

/* hdl/svc_rv_bpred_pkg.sv */
`default_nettype none

package svc_rv_bpred_pkg;

  // Data and PC width
  localparam int xlen = 32;

  // Direct-mapped BTB geometry
  localparam int btb_entries = 16;
  localparam int btb_idx_w = 4;
  // Tag covers everything above the index and the two byte-offset bits
  localparam int btb_tag_w = xlen - btb_idx_w - 2;

  // Return address stack geometry
  localparam int ras_depth = 4;
  localparam int ras_ptr_w = 2;

  typedef logic [xlen-1:0] pc_t;
  typedef logic [btb_idx_w-1:0] btb_idx_t;
  typedef logic [btb_tag_w-1:0] btb_tag_t;

  // 2-bit saturating counter, upper bit set means taken
  typedef logic [1:0] bpred_ctr_t;

  typedef logic [ras_ptr_w-1:0] ras_ptr_t;
  // One extra bit so a full stack can be counted
  typedef logic [ras_ptr_w:0] ras_cnt_t;

endpackage

`default_nettype wire

/* hdl/svc_rv_btb.sv */
`timescale 1ns/1ps
`default_nettype none

module svc_rv_btb import svc_rv_bpred_pkg::*; (
  input  logic                   clk,
  input  logic                   arst_n,
  input  pc_t                    lookup_pc,
  output logic                   hit,
  output bpred_ctr_t             ctr,
  output pc_t                    target,
  svc_rv_btb_update_if.btb       upd
);

  // Entry storage
  logic [btb_entries-1:0] valid;
  btb_tag_t               tags    [btb_entries];
  pc_t                    targets [btb_entries];
  bpred_ctr_t             ctrs    [btb_entries];

  btb_idx_t   lookup_idx;
  btb_tag_t   lookup_tag;
  btb_idx_t   upd_idx;
  btb_tag_t   upd_tag;
  logic       upd_hit;
  bpred_ctr_t upd_ctr;

  // Index from PC[5:2], tag from PC[31:6]
  assign lookup_idx = lookup_pc[btb_idx_w+1:2];
  assign lookup_tag = lookup_pc[xlen-1:btb_idx_w+2];

  // Combinational lookup
  assign hit    = valid[lookup_idx] && (tags[lookup_idx] == lookup_tag);
  assign ctr    = ctrs[lookup_idx];
  assign target = targets[lookup_idx];

  // Training side decode
  assign upd_idx = upd.pc[btb_idx_w+1:2];
  assign upd_tag = upd.pc[xlen-1:btb_idx_w+2];
  assign upd_hit = valid[upd_idx] && (tags[upd_idx] == upd_tag);

  // Next counter value for the entry being trained
  always_comb begin
    upd_ctr = ctrs[upd_idx];
    if (!upd_hit) begin
      // Fresh entry starts weakly biased toward the outcome
      upd_ctr = upd.taken ? 2'd2 : 2'd1;
    end else if (upd.taken) begin
      // Saturate at strongly taken
      if (upd_ctr != 2'd3) begin
        upd_ctr = upd_ctr + 2'd1;
      end
    end else begin
      // Saturate at strongly not taken
      if (upd_ctr != 2'd0) begin
        upd_ctr = upd_ctr - 2'd1;
      end
    end
  end

  // Valid bits are the only reset state
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid <= '0;
    end else if (upd.en) begin
      valid[upd_idx] <= 1'b1;
    end
  end

  // Tag, target and counter written on every training strobe
  always_ff @(posedge clk) begin
    if (upd.en) begin
      tags[upd_idx]    <= upd_tag;
      targets[upd_idx] <= upd.target;
      ctrs[upd_idx]    <= upd_ctr;
    end
  end

endmodule

`default_nettype wire

/* hdl/svc_rv_btb_update_if.sv */
`timescale 1ns/1ps
`default_nettype none

// BTB training write from EX resolution into the BTB
interface svc_rv_btb_update_if import svc_rv_bpred_pkg::*; ();

  // One-cycle write strobe
  logic en;
  // PC of the resolved branch or JAL
  pc_t  pc;
  // Resolved target
  pc_t  target;
  // Resolved direction
  logic taken;

  modport ex(output en, output pc, output target, output taken);

  modport btb(input en, input pc, input target, input taken);

endinterface

`default_nettype wire

/* hdl/svc_rv_ras.sv */
`timescale 1ns/1ps
`default_nettype none

module svc_rv_ras import svc_rv_bpred_pkg::*; (
  input  logic clk,
  input  logic arst_n,
  input  logic push,
  input  logic pop,
  input  pc_t  push_addr,
  output pc_t  top,
  output logic nonempty
);

  pc_t      stack [ras_depth];
  // Next free slot, wraps around the circular buffer
  ras_ptr_t ptr;
  ras_ptr_t ptr_prev;
  ras_cnt_t count;
  logic     pop_ok;

  assign ptr_prev = ptr - 1'b1;
  assign nonempty = (count != '0);
  assign top      = stack[ptr_prev];

  // Pop on an empty stack is dropped
  assign pop_ok = pop && nonempty;

  // Pointer and occupancy
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ptr   <= '0;
      count <= '0;
    end else if (push && pop_ok) begin
      // Replace in place, nothing moves
      ptr   <= ptr;
      count <= count;
    end else if (push) begin
      ptr <= ptr + 1'b1;
      // Oldest entry is overwritten once full
      if (count != ras_cnt_t'(ras_depth)) begin
        count <= count + 1'b1;
      end
    end else if (pop_ok) begin
      ptr   <= ptr_prev;
      count <= count - 1'b1;
    end
  end

  // Return addresses
  always_ff @(posedge clk) begin
    if (push && pop_ok) begin
      stack[ptr_prev] <= push_addr;
    end else if (push) begin
      stack[ptr] <= push_addr;
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=build
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module tb_svc_rv_bpred -Mdir "$build_dir" -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$build_dir/sim_tb" > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Simulation FAILED" "$log"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
exit 0

/* test/svc_rv_bpred_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module svc_rv_bpred_sva (
  input logic clk,
  input logic arst_n,
  input logic is_branch_ex,
  input logic is_jal_ex,
  input logic is_jalr_ex,
  input logic mispredicted_ex,
  input logic pc_sel_jump_ex,
  input logic upd_en,
  input logic pred_taken
);

  // Empty EX slot resolves nothing
  a_ex_idle: assert property (@(posedge clk) disable iff (!arst_n)
    !(is_branch_ex || is_jal_ex || is_jalr_ex) |-> !(mispredicted_ex || pc_sel_jump_ex))
    else $error("redirect or mispredict with no instruction in EX");

  // JALR targets are never trained
  a_no_jalr_train: assert property (@(posedge clk) disable iff (!arst_n)
    (is_jalr_ex && !is_branch_ex && !is_jal_ex) |-> !upd_en)
    else $error("BTB training write for a JALR");

  a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !pred_taken)
    else $error("taken prediction during reset");

endmodule

bind svc_rv_bpred svc_rv_bpred_sva u_sva (
  .clk             (clk),
  .arst_n          (arst_n),
  .is_branch_ex    (is_branch_ex),
  .is_jal_ex       (is_jal_ex),
  .is_jalr_ex      (is_jalr_ex),
  .mispredicted_ex (mispredicted_ex),
  .pc_sel_jump_ex  (pc_sel_jump_ex),
  .upd_en          (btb_upd.en),
  .pred_taken      (pred_taken)
);

`default_nettype wire

/* test/tb_svc_rv_bpred.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_svc_rv_bpred import svc_rv_bpred_pkg::*; ();

  logic clk;
  logic arst_n;
  logic fetch_valid;
  logic fetch_is_call;
  logic fetch_is_ret;
  pc_t  fetch_pc;
  logic pred_taken;
  pc_t  pred_target;
  logic is_branch_ex;
  logic is_jal_ex;
  logic is_jalr_ex;
  logic bpred_taken_ex;
  logic branch_taken_ex;
  pc_t  pc_ex;
  pc_t  jb_target_ex;
  pc_t  pred_target_ex;
  logic mispredicted_ex;
  logic pc_sel_jump_ex;

  // Reference BTB and RAS
  logic       ref_valid  [btb_entries];
  btb_tag_t   ref_tag    [btb_entries];
  pc_t        ref_target [btb_entries];
  bpred_ctr_t ref_ctr    [btb_entries];
  pc_t        ref_ras    [$];

  logic [15:0] lfsr = 16'd97;

  svc_rv_bpred u_svc_rv_bpred (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Fibonacci LFSR with taps 16 14 13 11, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], b};
      r    = {r[30:0], b};
    end
    return r;
  endfunction

  // Word aligned PC or target
  function automatic pc_t rand_pc();
    logic [31:0] r;
    r = rand_bits(30);
    return {r[29:0], 2'b00};
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  // Miss installs a weak counter, hit steps the counter with saturation
  function automatic void model_train(input pc_t pc, input pc_t target, input logic taken);
    btb_idx_t idx;
    idx = pc[5:2];
    if (!(ref_valid[idx] && ref_tag[idx] == pc[31:6])) begin
      ref_ctr[idx] = taken ? 2'd2 : 2'd1;
    end else if (taken && ref_ctr[idx] != 2'd3) begin
      ref_ctr[idx] = ref_ctr[idx] + 2'd1;
    end else if (!taken && ref_ctr[idx] != 2'd0) begin
      ref_ctr[idx] = ref_ctr[idx] - 2'd1;
    end
    ref_valid[idx]  = 1'b1;
    ref_tag[idx]    = pc[31:6];
    ref_target[idx] = target;
  endfunction

  function automatic logic model_pred(input pc_t pc);
    btb_idx_t idx;
    idx = pc[5:2];
    return ref_valid[idx] && ref_tag[idx] == pc[31:6] && ref_ctr[idx] >= 2'd2;
  endfunction

  task automatic clear_inputs();
    {fetch_valid, fetch_is_call, fetch_is_ret} = '0;
    {is_branch_ex, is_jal_ex, is_jalr_ex, bpred_taken_ex, branch_taken_ex} = '0;
    fetch_pc       = '0;
    pc_ex          = '0;
    jb_target_ex   = '0;
    pred_target_ex = '0;
  endtask

  // Plain fetch lookup, no stack activity
  task automatic fetch_probe(input pc_t pc);
    @(negedge clk);
    clear_inputs();
    fetch_pc = pc;
    #5;
    check("pred_taken", 32'(pred_taken), 32'(model_pred(pc)));
    if (model_pred(pc)) begin
      check("pred_target", pred_target, ref_target[pc[5:2]]);
    end
  endtask

  // One EX cycle, outputs checked mid cycle before the training edge
  task automatic ex_drive(input logic br, input logic jal, input logic jalr, input logic bp,
                          input logic bt, input pc_t pc, input pc_t jt, input pc_t pt);
    @(negedge clk);
    clear_inputs();
    {is_branch_ex, is_jal_ex, is_jalr_ex} = {br, jal, jalr};
    {bpred_taken_ex, branch_taken_ex}     = {bp, bt};
    {pc_ex, jb_target_ex, pred_target_ex} = {pc, jt, pt};
    #5;
    check("mispredicted_ex", 32'(mispredicted_ex), 32'(br && (bp != bt)));
    check("pc_sel_jump_ex", 32'(pc_sel_jump_ex), 32'(jalr && (!bp || pt != jt)));
    if (br || jal) begin
      model_train(pc, jt, jal ? 1'b1 : bt);
    end
    @(negedge clk);
    clear_inputs();
  endtask

  task automatic cold_start();
    repeat (8) begin
      fetch_probe(rand_pc());
      check("pred_taken", 32'(pred_taken), 32'd0);
    end
  endtask

  task automatic counter_training();
    pc_t pc;
    pc = rand_pc();
    repeat (12) begin
      ex_drive(1'b1, 1'b0, 1'b0, 1'b0, 1'(rand_bits(1)), pc, rand_pc(), '0);
      fetch_probe(pc);
    end
  endtask

  // Same index, inverted tag
  task automatic aliasing();
    pc_t pc;
    pc_t alias_pc;
    pc       = rand_pc();
    alias_pc = {~pc[31:6], pc[5:0]};
    // First entry driven down to strongly not taken
    ex_drive(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, pc, rand_pc(), '0);
    ex_drive(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, pc, rand_pc(), '0);
    fetch_probe(pc);
    // Taken alias installs a fresh weak taken counter in the same slot
    ex_drive(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, alias_pc, rand_pc(), '0);
    fetch_probe(pc);
    check("pred_taken", 32'(pred_taken), 32'd0);
    fetch_probe(alias_pc);
    check("pred_taken", 32'(pred_taken), 32'd1);
  endtask

  task automatic ex_resolution();
    logic [1:0] kind;
    pc_t        pc;
    pc_t        jt;
    pc_t        pt;
    repeat (24) begin
      // Kind 0 is an empty EX slot, then branch, JAL, JALR
      kind = 2'(rand_bits(2));
      pc   = rand_pc();
      jt   = rand_pc();
      pt   = 1'(rand_bits(1)) ? jt : rand_pc();
      ex_drive(kind == 2'd1, kind == 2'd2, kind == 2'd3, 1'(rand_bits(1)), 1'(rand_bits(1)),
               pc, jt, pt);
      fetch_probe(pc);
    end
    // JAL on a fresh PC must predict taken next time
    pc = rand_pc();
    ex_drive(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, pc, rand_pc(), '0);
    fetch_probe(pc);
    check("pred_taken", 32'(pred_taken), 32'd1);
  endtask

  task automatic ras_calls_returns();
    pc_t pc;
    repeat (6) begin
      pc = rand_pc();
      @(negedge clk);
      clear_inputs();
      {fetch_valid, fetch_is_call, fetch_pc} = {1'b1, 1'b1, pc};
      #5;
      // Call direction still comes from the BTB
      check("pred_taken", 32'(pred_taken), 32'(model_pred(pc)));
      ref_ras.push_back(pc + 32'd4);
      if (ref_ras.size() > ras_depth) begin
        ref_ras.pop_front();
      end
    end
    repeat (6) begin
      pc = rand_pc();
      @(negedge clk);
      clear_inputs();
      {fetch_valid, fetch_is_ret, fetch_pc} = {1'b1, 1'b1, pc};
      #5;
      if (ref_ras.size() > 0) begin
        check("pred_taken", 32'(pred_taken), 32'd1);
        check("pred_target", pred_target, ref_ras[$]);
        ref_ras.pop_back();
      end else begin
        check("pred_taken", 32'(pred_taken), 32'(model_pred(pc)));
      end
    end
    @(negedge clk);
    clear_inputs();
  endtask

  // Global cycle limit
  initial begin
    for (int c = 0; c < 3000; c++) begin
      @(posedge clk);
    end
    $display("timeout, the test sequence did not finish in time");
    $display("Simulation FAILED");
    $fatal(1);
  end

  initial begin
    logic settled;
    for (int i = 0; i < btb_entries; i++) begin
      ref_valid[i] = 1'b0;
    end
    clear_inputs();
    arst_n = 1'b0;
    repeat (3) @(negedge clk);
    arst_n  = 1'b1;
    settled = 1'b0;
    for (int i = 0; i < 10 && !settled; i++) begin
      @(negedge clk);
      settled = (pred_taken === 1'b0) && (mispredicted_ex === 1'b0)
                && (pc_sel_jump_ex === 1'b0);
    end
    if (!settled) begin
      $display("outputs did not settle low after reset");
      $display("Simulation FAILED");
      $fatal(1);
    end
    cold_start();
    counter_training();
    aliasing();
    ex_resolution();
    ras_calls_returns();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire
